// File: build.f
src/spi_pkg.sv
src/spi_dispatch.sv
src/spi_lane_master.sv
src/spi_rx_collect.sv
src/spi_multi_top.sv
verif/spi_slave_model.sv
verif/tb_spi_multi.sv

// File: Bender.yml
package:
  name: spi_multi

sources:
  - src/spi_pkg.sv
  - src/spi_dispatch.sv
  - src/spi_lane_master.sv
  - src/spi_rx_collect.sv
  - src/spi_multi_top.sv
  - target: simulation
    files:
      - verif/spi_slave_model.sv
      - verif/tb_spi_multi.sv

// File: verif/tb_spi_multi.sv
// Four lanes in SPI mode 1 at 2 clocks per half bit; every wait gives up after TIMEOUT cycles
module tb_spi_multi;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int          NUM_LANES         = 4;
  localparam int          SPI_MODE          = 1;
  localparam int          CLKS_PER_HALF_BIT = 2;
  localparam int          LANE_W            = 2;
  localparam logic [7:0]  SLAVE_START       = 8'hA5;
  localparam logic [31:0] LFSR_SEED         = 32'hf4398ec1;
  localparam int          N_RANDOM          = 200;
  localparam int          TIMEOUT           = 2000;  // Cycles per wait
  localparam logic        IDLE_CLK          = (SPI_MODE == 2) || (SPI_MODE == 3);

  logic                  i_Clk;
  logic                  i_Rst_L;
  logic                  i_tx_dv;
  logic [LANE_W-1:0]     i_tx_lane;
  logic [7:0]            i_tx_byte;
  logic [NUM_LANES-1:0]  o_tx_ready;
  logic                  o_rx_dv;
  logic [7:0]            o_rx_byte;
  logic [LANE_W-1:0]     o_rx_lane;
  logic [NUM_LANES-1:0]  o_spi_clk;
  logic [NUM_LANES-1:0]  o_spi_mosi;
  wire  [NUM_LANES-1:0]  spi_miso;     // One slave per bit

  logic [7:0]   sent_q [NUM_LANES][$];  // Bytes still waiting for their reply
  logic [7:0]   last_sent [NUM_LANES];  // Byte of the last answered transfer
  int           n_done [NUM_LANES];     // Replies seen per lane
  int           n_sent;
  int           rx_total;
  logic [31:0]  lfsr;
  string        test_name;

  always #10 i_Clk = ~i_Clk;            // 20 ns period

  spi_multi_top #(
    .NUM_LANES(NUM_LANES),
    .SPI_MODE(SPI_MODE),
    .CLKS_PER_HALF_BIT(CLKS_PER_HALF_BIT)
  ) UUT (
    .i_Clk(i_Clk), .i_Rst_L(i_Rst_L),
    .i_tx_dv(i_tx_dv), .i_tx_lane(i_tx_lane), .i_tx_byte(i_tx_byte), .o_tx_ready(o_tx_ready),
    .o_rx_dv(o_rx_dv), .o_rx_byte(o_rx_byte), .o_rx_lane(o_rx_lane),
    .o_spi_clk(o_spi_clk), .o_spi_mosi(o_spi_mosi), .i_spi_miso(spi_miso)
  );

  for (genvar g = 0; g < NUM_LANES; g++)
  begin : g_slave
    spi_slave_model #(.SPI_MODE(SPI_MODE), .START_BYTE(SLAVE_START)) u_slave (
      .i_spi_clk(o_spi_clk[g]), .i_spi_mosi(o_spi_mosi[g]), .o_spi_miso(spi_miso[g])
    );
  end

  //////////////////////////////////////////////////
  // Reference model and helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] galois_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);  // x^32+x^22+x^2+x+1
  endfunction

  // First reply of a lane is the slave start value and later ones invert the byte before
  function automatic logic [7:0] ref_reply(input int k, input logic [7:0] prev_byte);
    return (k == 0) ? SLAVE_START : ~prev_byte;
  endfunction

  task automatic take_bits(input int n, output logic [7:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v    = {v[6:0], lfsr[0]};
      lfsr = galois_step(lfsr);     // One step per bit
    end
  endtask

  task automatic stop_on_error();
    $display("TB FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp)
    else
    begin
      $display("** Error [%s] %s expected %0h actual %0h", test_name, what, exp, act);
      stop_on_error();
    end
  endtask

  task automatic wait_lane_ready(input int lane);
    int cycles;
    cycles = 0;
    @(negedge i_Clk);                      // Outputs settled mid-cycle
    while (!o_tx_ready[lane] && cycles <= TIMEOUT)
    begin
      @(negedge i_Clk);
      cycles++;
    end
    assert (o_tx_ready[lane])
    else
    begin
      $display("Timeout, lane %0d never became ready in test %s", lane, test_name);
      stop_on_error();
    end
  endtask

  task automatic wait_all_ready();
    int cycles;
    cycles = 0;
    @(negedge i_Clk);
    while (o_tx_ready != '1 && cycles <= TIMEOUT)
    begin
      @(negedge i_Clk);
      cycles++;
    end
    check_value("o_tx_ready", {NUM_LANES{1'b1}}, o_tx_ready);
  endtask

  task automatic wait_all_replies();
    int cycles;
    cycles = 0;
    while (rx_total < n_sent && cycles <= TIMEOUT)
    begin
      @(negedge i_Clk);
      cycles++;
    end
    assert (rx_total >= n_sent)
    else
    begin
      $display("Timeout, only %0d of %0d replies came back in test %s", rx_total, n_sent,
               test_name);
      stop_on_error();
    end
  endtask

  task automatic issue_byte(input int lane, input logic [7:0] val);
    @(posedge i_Clk);
    i_tx_dv   <= 1'b1;
    i_tx_lane <= LANE_W'(lane);
    i_tx_byte <= val;
    sent_q[lane].push_back(val);
    n_sent++;
  endtask

  task automatic end_strobe();
    @(posedge i_Clk);                      // Edge where the DUT takes the last strobe
    i_tx_dv <= 1'b0;
  endtask

  task automatic send_byte(input int lane, input logic [7:0] val);
    wait_lane_ready(lane);
    issue_byte(lane, val);
    end_strobe();
  endtask

  //////////////////////////////////////////////////
  // Scoreboard
  //////////////////////////////////////////////////

  always @(posedge i_Clk)
  begin
    logic [7:0] sent;
    int         lane;
    if (i_Rst_L && o_rx_dv)
    begin
      lane = int'(o_rx_lane);
      assert (sent_q[lane].size() > 0)
      else
      begin
        $display("Reply from lane %0d with no byte outstanding in test %s", lane, test_name);
        stop_on_error();
      end
      sent = sent_q[lane].pop_front();
      check_value("rx byte", ref_reply(n_done[lane], last_sent[lane]), o_rx_byte);
      last_sent[lane] = sent;              // Next reply of this lane is its inverse
      n_done[lane]++;
      rx_total++;
    end
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  initial
  begin
    logic [7:0] val;
    logic [7:0] pick;
    int         base [NUM_LANES];
    i_Clk     = 1'b0;
    i_Rst_L   = 1'b0;
    i_tx_dv   = 1'b0;
    i_tx_lane = '0;
    i_tx_byte = '0;
    lfsr      = LFSR_SEED;
    n_sent    = 0;
    rx_total  = 0;
    test_name = "reset";
    for (int l = 0; l < NUM_LANES; l++)
    begin
      n_done[l]    = 0;
      last_sent[l] = '0;
    end

    // Reset held for 3 cycles with outputs quiet
    repeat (2) @(posedge i_Clk);
    @(negedge i_Clk);
    check_value("o_tx_ready in reset", 0, o_tx_ready);
    check_value("o_rx_dv in reset", 0, o_rx_dv);
    @(posedge i_Clk);
    i_Rst_L <= 1'b1;

    test_name = "after_reset";
    wait_all_ready();
    check_value("o_rx_dv", 0, o_rx_dv);
    check_value("SCLK idle", {NUM_LANES{IDLE_CLK}}, o_spi_clk);

    test_name = "each_lane";               // Start value from every slave
    for (int l = 0; l < NUM_LANES; l++)
    begin
      take_bits(8, val);
      send_byte(l, val);
      wait_all_replies();
    end

    test_name = "back_to_back";
    take_bits(8, val);
    send_byte(2, val);
    take_bits(8, val);
    send_byte(2, val);                     // Lane is busy so this one stays pending
    @(negedge i_Clk);
    check_value("ready of busy lane", 0, o_tx_ready[2]);
    wait_lane_ready(2);
    wait_all_replies();

    test_name = "all_lanes";
    wait_all_ready();
    for (int l = 0; l < NUM_LANES; l++)
      base[l] = n_done[l];
    for (int l = 0; l < NUM_LANES; l++)
    begin
      take_bits(8, val);
      issue_byte(l, val);                  // Consecutive cycles make completions collide
    end
    end_strobe();
    wait_all_replies();
    for (int l = 0; l < NUM_LANES; l++)
      check_value("replies per lane", base[l] + 1, n_done[l]);

    test_name = "random";
    for (int i = 0; i < N_RANDOM; i++)
    begin
      take_bits(LANE_W, pick);
      take_bits(8, val);
      send_byte(int'(pick[LANE_W-1:0]), val);
    end
    wait_all_replies();
    for (int l = 0; l < NUM_LANES; l++)
      check_value("queue depth", 0, sent_q[l].size());

    $display("TB PASSED");
    $finish;
  end

endmodule : tb_spi_multi

// File: verif/spi_slave_model.sv
// No chip select, so framing relies on counting 8 samples from the first SCLK edge after reset
module spi_slave_model
  #(parameter int         SPI_MODE   = 0,
    parameter logic [7:0] START_BYTE = 8'hA5)
  (
    input  logic i_spi_clk,
    input  logic i_spi_mosi,
    output logic o_spi_miso
  );

  timeunit 1ns;
  timeprecision 1ps;

  localparam logic CPOL = (SPI_MODE == 2) || (SPI_MODE == 3);  // SCLK idle level
  localparam logic CPHA = (SPI_MODE == 1) || (SPI_MODE == 3);  // 1: sample on trailing

  logic [7:0] r_tx;    // Bits still to send, MSB on top
  logic [7:0] r_rx;    // Bits taken from MOSI so far
  int         n_bits;  // Samples in the current byte
  logic       r_last;  // Previous SCLK level

  initial
  begin
    r_tx       = START_BYTE;
    r_rx       = '0;
    n_bits     = 0;
    r_last     = CPOL;                           // The reset value of SCLK is no edge
    o_spi_miso = CPHA ? 1'b0 : START_BYTE[7];    // CPHA=0 shows the MSB before any edge
  end

  always @(i_spi_clk)
  begin
    logic lead;
    logic trail;
    lead   = (r_last === CPOL) && (i_spi_clk === ~CPOL);
    trail  = (r_last === ~CPOL) && (i_spi_clk === CPOL);
    r_last = i_spi_clk;
    if ((lead && !CPHA) || (trail && CPHA))
    begin
      r_rx   = {r_rx[6:0], i_spi_mosi};          // MSB first in
      n_bits = n_bits + 1;
    end
    else if (lead || trail)
    begin
      if (n_bits == 8)
      begin
        r_tx   = ~r_rx;                          // Reply to a byte is its inverse
        n_bits = 0;
      end
      else if (!CPHA)
        r_tx = r_tx << 1;                        // Current bit was already shown
      o_spi_miso <= r_tx[7];
      if (CPHA)
        r_tx = r_tx << 1;
    end
  end

endmodule : spi_slave_model

// File: src/spi_multi_top.sv
// NUM_LANES 1..32, one shared SPI mode and rate for all lanes; chip selects are left to the user
module spi_multi_top
  #(parameter int NUM_LANES         = 4,
    parameter int SPI_MODE          = 0,
    parameter int CLKS_PER_HALF_BIT = 2,
    localparam int LANE_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1)
  (
    input  logic                        i_Clk,
    input  logic                        i_Rst_L,
    // Host transmit side
    input  logic                        i_tx_dv,
    input  logic [LANE_W-1:0]           i_tx_lane,
    input  logic [spi_pkg::BYTE_W-1:0]  i_tx_byte,
    output logic [NUM_LANES-1:0]        o_tx_ready,
    // Host receive side
    output logic                        o_rx_dv,
    output logic [spi_pkg::BYTE_W-1:0]  o_rx_byte,
    output logic [LANE_W-1:0]           o_rx_lane,
    // SPI pins, one bit per lane
    output logic [NUM_LANES-1:0]        o_spi_clk,
    output logic [NUM_LANES-1:0]        o_spi_mosi,
    input  logic [NUM_LANES-1:0]        i_spi_miso
  );

  import spi_pkg::*;

  logic [NUM_LANES-1:0]              w_lane_ready;
  logic [NUM_LANES-1:0]              w_lane_start;
  logic [BYTE_W-1:0]                 w_lane_byte;   // Shared by all lanes
  logic [NUM_LANES-1:0]              w_rx_dv;
  logic [NUM_LANES-1:0][BYTE_W-1:0]  w_rx_byte;

  spi_dispatch #(.NUM_LANES(NUM_LANES)) u_dispatch (
    .i_Clk(i_Clk), .i_Rst_L(i_Rst_L),
    .i_tx_dv(i_tx_dv), .i_tx_lane(i_tx_lane), .i_tx_byte(i_tx_byte),
    .i_lane_ready(w_lane_ready), .o_tx_ready(o_tx_ready),
    .o_lane_start(w_lane_start), .o_lane_byte(w_lane_byte)
  );

  for (genvar g = 0; g < NUM_LANES; g++)
  begin : g_lane
    spi_lane_master #(.SPI_MODE(SPI_MODE), .CLKS_PER_HALF_BIT(CLKS_PER_HALF_BIT)) u_lane (
      .i_Clk(i_Clk), .i_Rst_L(i_Rst_L),
      .i_start(w_lane_start[g]), .i_byte(w_lane_byte), .o_ready(w_lane_ready[g]),
      .o_rx_dv(w_rx_dv[g]), .o_rx_byte(w_rx_byte[g]),
      .o_spi_clk(o_spi_clk[g]), .o_spi_mosi(o_spi_mosi[g]), .i_spi_miso(i_spi_miso[g])
    );
  end

  spi_rx_collect #(.NUM_LANES(NUM_LANES)) u_collect (
    .i_Clk(i_Clk), .i_Rst_L(i_Rst_L),
    .i_rx_dv(w_rx_dv), .i_rx_byte(w_rx_byte),
    .o_rx_dv(o_rx_dv), .o_rx_byte(o_rx_byte), .o_rx_lane(o_rx_lane)
  );

endmodule : spi_multi_top

// File: src/spi_rx_collect.sv
// No back-pressure, host takes every o_rx_dv; each lane strobes at most once per 32 cycles
module spi_rx_collect
  #(parameter int NUM_LANES = 4,
    localparam int LANE_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1)
  (
    input  logic                                        i_Clk,
    input  logic                                        i_Rst_L,
    input  logic [NUM_LANES-1:0]                        i_rx_dv,    // Per-lane done pulses
    input  logic [NUM_LANES-1:0][spi_pkg::BYTE_W-1:0]   i_rx_byte,
    output logic                                        o_rx_dv,
    output logic [spi_pkg::BYTE_W-1:0]                  o_rx_byte,
    output logic [LANE_W-1:0]                           o_rx_lane   // Source lane of o_rx_byte
  );

  import spi_pkg::*;

  collect_state_e        r_state;
  logic [NUM_LANES-1:0]  r_full;              // Holding slot occupied
  logic [BYTE_W-1:0]     r_slot [NUM_LANES];
  logic [LANE_W-1:0]     r_ptr;               // Round-robin start point
  logic                  pick_hit;
  logic [LANE_W-1:0]     pick_lane;

  assign o_rx_dv = (r_state == COL_EMIT);

  // First full slot at or after r_ptr, wrapping
  always_comb
  begin
    int idx;
    pick_hit  = 1'b0;
    pick_lane = '0;
    for (int k = NUM_LANES - 1; k >= 0; k--)
    begin
      idx = int'(r_ptr) + k;
      if (idx >= NUM_LANES)
        idx = idx - NUM_LANES;
      if (r_full[idx])
      begin
        pick_hit  = 1'b1;                    // Smallest distance wins
        pick_lane = LANE_W'(idx);
      end
    end
  end

  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
    begin
      r_state <= COL_IDLE;
      r_full  <= '0;
      r_ptr   <= '0;
    end
    else
    begin
      r_full  <= r_full | i_rx_dv;           // Filled slots never collide with the drain
      r_state <= pick_hit ? COL_EMIT : COL_IDLE;
      if (pick_hit)
      begin
        r_full[pick_lane] <= 1'b0;
        r_ptr <= (pick_lane == LANE_W'(NUM_LANES - 1)) ? '0 : pick_lane + 1'b1;
      end
    end
  end

  always_ff @(posedge i_Clk)
  begin
    for (int i = 0; i < NUM_LANES; i++)
      if (i_rx_dv[i])
        r_slot[i] <= i_rx_byte[i];
    if (pick_hit)
    begin
      o_rx_byte <= r_slot[pick_lane];
      o_rx_lane <= pick_lane;
    end
  end

  a_no_slot_overrun: assert property (@(posedge i_Clk) disable iff (!i_Rst_L)
    (i_rx_dv & r_full) == '0);

endmodule : spi_rx_collect

// File: src/spi_lane_master.sv
// Needs CLKS_PER_HALF_BIT >= 2; mode fixed at elaboration, no chip select, i_start only when ready
module spi_lane_master
  #(parameter int SPI_MODE          = 0,
    parameter int CLKS_PER_HALF_BIT = 2)
  (
    input  logic                        i_Clk,
    input  logic                        i_Rst_L,
    input  logic                        i_start,     // One-cycle start, only while o_ready
    input  logic [spi_pkg::BYTE_W-1:0]  i_byte,      // Sampled with i_start
    output logic                        o_ready,     // Idle and able to accept i_start
    output logic                        o_rx_dv,     // One-cycle pulse with last sample
    output logic [spi_pkg::BYTE_W-1:0]  o_rx_byte,
    output logic                        o_spi_clk,
    output logic                        o_spi_mosi,
    input  logic                        i_spi_miso
  );

  import spi_pkg::*;

  localparam logic CPOL  = (SPI_MODE == 2) || (SPI_MODE == 3);  // SCLK idle level
  localparam logic CPHA  = (SPI_MODE == 1) || (SPI_MODE == 3);  // 1: sample on trailing
  localparam int   CNT_W = $clog2(CLKS_PER_HALF_BIT * 2);
  localparam int   BIT_W = $clog2(BYTE_W);
  localparam int   EDG_W = $clog2(2 * BYTE_W + 1);

  spi_lane_state_e   r_state;
  logic [CNT_W-1:0]  r_clk_cnt;     // Position within one SCLK period
  logic [EDG_W-1:0]  r_edges;       // SCLK edges still to make
  logic              r_lead;        // Strobe, leading edge just made
  logic              r_trail;       // Strobe, trailing edge just made
  logic              r_spi_clk;     // Undelayed SCLK
  logic [BYTE_W-1:0] r_tx_byte;
  logic [BIT_W-1:0]  r_tx_bit;
  logic [BIT_W-1:0]  r_rx_bit;
  logic              w_sample;
  logic              w_drive;

  // CPHA=0 samples on leading and drives on trailing; CPHA=1 swaps them
  assign w_sample = (r_state == LANE_SHIFT) && ((r_lead && !CPHA) || (r_trail && CPHA));
  assign w_drive  = (r_state == LANE_SHIFT) && ((r_trail && !CPHA) || (r_lead && CPHA));

  //////////////////////////////////////////////////
  // FSM and SCLK edge generation
  //////////////////////////////////////////////////

  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
    begin
      r_state   <= LANE_IDLE;
      o_ready   <= 1'b0;
      r_edges   <= '0;
      r_clk_cnt <= '0;
      r_lead    <= 1'b0;
      r_trail   <= 1'b0;
      r_spi_clk <= CPOL;
    end
    else
    begin
      r_lead  <= 1'b0;
      r_trail <= 1'b0;
      case (r_state)
        LANE_IDLE:
        begin
          if (i_start)
          begin
            o_ready <= 1'b0;
            r_state <= LANE_LOAD;
          end
          else
            o_ready <= 1'b1;                 // Rises a cycle after the last o_rx_dv
        end
        LANE_LOAD:
        begin
          r_edges   <= EDG_W'(2 * BYTE_W);   // Always 16 edges per byte
          r_clk_cnt <= '0;
          r_state   <= LANE_SHIFT;
        end
        LANE_SHIFT:
        begin
          if (r_edges == '0)
            r_state <= LANE_IDLE;            // SCLK is back at CPOL here
          else if (r_clk_cnt == CNT_W'(CLKS_PER_HALF_BIT * 2 - 1))
          begin
            r_edges   <= r_edges - 1'b1;
            r_trail   <= 1'b1;
            r_clk_cnt <= '0;
            r_spi_clk <= ~r_spi_clk;
          end
          else if (r_clk_cnt == CNT_W'(CLKS_PER_HALF_BIT - 1))
          begin
            r_edges   <= r_edges - 1'b1;
            r_lead    <= 1'b1;
            r_clk_cnt <= r_clk_cnt + 1'b1;
            r_spi_clk <= ~r_spi_clk;
          end
          else
            r_clk_cnt <= r_clk_cnt + 1'b1;
        end
        default: r_state <= LANE_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_Clk)
  begin
    if (r_state == LANE_IDLE && i_start)
      r_tx_byte <= i_byte;                   // Local copy, the shared bus moves on
  end

  //////////////////////////////////////////////////
  // MOSI and MISO
  //////////////////////////////////////////////////

  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
    begin
      o_spi_mosi <= 1'b0;
      r_tx_bit   <= BIT_W'(BYTE_W - 1);
    end
    else if (r_state == LANE_LOAD)
    begin
      if (!CPHA)
      begin
        o_spi_mosi <= r_tx_byte[BYTE_W-1];   // First bit before any edge
        r_tx_bit   <= BIT_W'(BYTE_W - 2);
      end
      else
        r_tx_bit <= BIT_W'(BYTE_W - 1);
    end
    else if (w_drive)
    begin
      o_spi_mosi <= r_tx_byte[r_tx_bit];
      r_tx_bit   <= r_tx_bit - 1'b1;
    end
  end

  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
    begin
      o_rx_dv  <= 1'b0;
      r_rx_bit <= BIT_W'(BYTE_W - 1);
    end
    else
    begin
      o_rx_dv <= 1'b0;
      if (r_state == LANE_LOAD)
        r_rx_bit <= BIT_W'(BYTE_W - 1);     // MSB arrives first
      else if (w_sample)
      begin
        r_rx_bit <= r_rx_bit - 1'b1;
        if (r_rx_bit == '0)
          o_rx_dv <= 1'b1;
      end
    end
  end

  always_ff @(posedge i_Clk)
  begin
    if (w_sample)
      o_rx_byte[r_rx_bit] <= i_spi_miso;
  end

  // One cycle delay keeps SCLK lined up with MOSI
  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
      o_spi_clk <= CPOL;
    else
      o_spi_clk <= r_spi_clk;
  end

  a_start_when_ready: assert property (@(posedge i_Clk) disable iff (!i_Rst_L)
    i_start |-> o_ready);
  a_idle_clk_level: assert property (@(posedge i_Clk) disable iff (!i_Rst_L)
    (r_state == LANE_IDLE) |-> (o_spi_clk == CPOL));

endmodule : spi_lane_master

// File: src/spi_dispatch.sv
// Host may strobe a lane only while its o_tx_ready bit is high; one lane start per cycle at most
module spi_dispatch
  #(parameter int NUM_LANES = 4,
    localparam int LANE_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1)
  (
    input  logic                        i_Clk,
    input  logic                        i_Rst_L,
    input  logic                        i_tx_dv,       // One-cycle host strobe
    input  logic [LANE_W-1:0]           i_tx_lane,     // Target lane of i_tx_byte
    input  logic [spi_pkg::BYTE_W-1:0]  i_tx_byte,
    input  logic [NUM_LANES-1:0]        i_lane_ready,  // Engine idle levels
    output logic [NUM_LANES-1:0]        o_tx_ready,    // Pending buffer empty
    output logic [NUM_LANES-1:0]        o_lane_start,  // One-hot start pulse
    output logic [spi_pkg::BYTE_W-1:0]  o_lane_byte    // Shared byte bus to all lanes
  );

  import spi_pkg::*;

  logic [NUM_LANES-1:0]  r_valid;              // Slot holds a byte
  logic [BYTE_W-1:0]     r_byte [NUM_LANES];   // Pending byte per lane
  logic                  r_alive;              // Low until first clock after reset
  logic                  pick_hit;
  logic [LANE_W-1:0]     pick_lane;

  assign o_tx_ready = r_alive ? ~r_valid : '0;  // Held low through reset

  // Fixed priority so the lowest lane index wins
  always_comb
  begin
    pick_hit  = 1'b0;
    pick_lane = '0;
    for (int i = NUM_LANES - 1; i >= 0; i--)
    begin
      if (r_valid[i] && i_lane_ready[i])
      begin
        pick_hit  = 1'b1;
        pick_lane = LANE_W'(i);
      end
    end
  end

  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
    begin
      r_valid      <= '0;
      r_alive      <= 1'b0;
      o_lane_start <= '0;
    end
    else
    begin
      r_alive      <= 1'b1;
      o_lane_start <= '0;                   // Pulse only
      if (i_tx_dv)
        r_valid[i_tx_lane] <= 1'b1;          // Never the slot being drained
      if (pick_hit)
      begin
        r_valid[pick_lane]      <= 1'b0;     // Empty it as the start goes out
        o_lane_start[pick_lane] <= 1'b1;
      end
    end
  end

  // Payload path
  always_ff @(posedge i_Clk)
  begin
    if (i_tx_dv)
      r_byte[i_tx_lane] <= i_tx_byte;
    if (pick_hit)
      o_lane_byte <= r_byte[pick_lane];      // Valid alongside o_lane_start
  end

  a_no_full_write: assert property (@(posedge i_Clk) disable iff (!i_Rst_L)
    i_tx_dv |-> !r_valid[i_tx_lane]);
  a_start_onehot: assert property (@(posedge i_Clk) disable iff (!i_Rst_L)
    $onehot0(o_lane_start) && ((o_lane_start & ~i_lane_ready) == '0));

endmodule : spi_dispatch

// File: src/spi_pkg.sv
// Word width is fixed at 8 bits; SPI mode and clock rate are elaboration-time parameters only
package spi_pkg;

  //////////////////////////////////////////////////
  // Serial word
  //////////////////////////////////////////////////

  localparam int BYTE_W = 8;  // Bits per SPI transfer, MSB first

  //////////////////////////////////////////////////
  // State encodings
  //////////////////////////////////////////////////

  // Lane engine
  typedef enum logic [1:0] {
    LANE_IDLE  = 2'd0,  // Ready for a new byte
    LANE_LOAD  = 2'd1,  // One cycle, first bit out when CPHA=0
    LANE_SHIFT = 2'd2   // Running the 16 SCLK edges
  } spi_lane_state_e;

  // Receive collector output stage
  typedef enum logic {
    COL_IDLE = 1'b0,  // Nothing presented
    COL_EMIT = 1'b1   // o_rx_byte is valid this cycle
  } collect_state_e;

endpackage : spi_pkg
